// ==== verilog/sram_mpa_pkg.sv ====
// Shared widths, master indices, AHB encodings and SRAM word view; referenced by scoped name

package sram_mpa_pkg;

  // ------------------------------
  // Masters sharing the SRAM
  // ------------------------------
  localparam int NUM_MASTERS = 3;

  // Bit positions in request, grant and owner vectors
  localparam int PROC_ID = 0;
  localparam int DMA0_ID = 1;
  localparam int DMA1_ID = 2;

  // ------------------------------
  // Data path widths
  // ------------------------------
  // Full SRAM word
  localparam int WORD_W = 64;
  // Processor lane, half a word
  localparam int LANE_W = 32;
  // One enable per byte of the word
  localparam int BE_W = 8;

  // ------------------------------
  // AHB encodings
  // ------------------------------
  localparam logic [1:0] HSIZE_BYTE = 2'b00;
  localparam logic [1:0] HSIZE_HALF = 2'b01;
  localparam logic [1:0] HSIZE_WORD = 2'b10;

  // Set for NONSEQ and SEQ, clear for IDLE and BUSY
  localparam int HTRANS_ACTIVE_BIT = 1;

  // ------------------------------
  // SRAM word, two decodes
  // ------------------------------
  // Lane view for processor read return and write replication,
  // byte view for enable merging
  typedef union packed {
    logic [1:0][LANE_W-1:0]  lane;
    logic [BE_W-1:0][7:0]    bytes;
  } ram_word_u;

endpackage

// ==== verilog/ahb_port.sv ====
// Processor AHB slave front end; holds one accepted transfer as an SRAM request until granted
`timescale 1ns/1ps

module ahb_port
#(
  parameter int ADDR_WIDTH = 12
)
(
  input  logic                                 clk,
  input  logic                                 rst_n,

  // AHB address phase
  input  logic                                 hsel,
  input  logic [ADDR_WIDTH-1:0]                haddr,
  input  logic [1:0]                           htrans,
  input  logic                                 hwrite,
  input  logic [1:0]                           hsize,
  input  logic                                 hready_in,
  output logic                                 hready,

  // Arbiter side
  output logic                                 req,
  input  logic                                 gnt,

  // Captured SRAM access
  output logic [ADDR_WIDTH-4:0]                ram_a,
  output logic                                 ram_lane_hi,
  output logic [sram_mpa_pkg::BE_W-1:0]        ram_we
);

  // ------------------------------
  // Local signals
  // ------------------------------
  logic                                   accept;
  logic                                   pending;
  logic [sram_mpa_pkg::BE_W/2-1:0]        lane_be;
  logic [sram_mpa_pkg::BE_W-1:0]          we_next;
  logic [ADDR_WIDTH-4:0]                  addr_q;
  logic                                   lane_hi_q;
  logic [sram_mpa_pkg::BE_W-1:0]          we_q;

  // Address phase taken only while the slave is ready
  assign accept = hsel & htrans[sram_mpa_pkg::HTRANS_ACTIVE_BIT] & hready_in & hready;

  // ------------------------------
  // Byte enables within the lane
  // ------------------------------
  always_comb
  begin
    case (hsize)
      sram_mpa_pkg::HSIZE_BYTE:
      begin
        lane_be = 4'b0001 << haddr[1:0];
      end
      sram_mpa_pkg::HSIZE_HALF:
      begin
        lane_be = haddr[1] ? 4'b1100 : 4'b0011;
      end
      default:
      begin
        // Word, and anything wider is clipped to the lane
        lane_be = 4'b1111;
      end
    endcase
  end

  // Lane enables placed in the upper or lower half
  // Reads get none
  always_comb
  begin
    we_next = '0;
    if (hwrite)
    begin
      if (haddr[2])
        we_next = {lane_be, 4'b0000};
      else
        we_next = {4'b0000, lane_be};
    end
  end

  // ------------------------------
  // Pending transfer
  // ------------------------------
  // Set on acceptance, cleared in the grant cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending <= 1'b0;
    end
    else if (accept)
    begin
      pending <= 1'b1;
    end
    else if (gnt)
    begin
      pending <= 1'b0;
    end
  end

  // Address phase payload
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q    <= haddr[ADDR_WIDTH-1:3];
      lane_hi_q <= haddr[2];
      we_q      <= we_next;
    end
  end

  // Wait states until the cycle after the grant
  assign hready      = ~pending;
  assign req         = pending;
  assign ram_a       = addr_q;
  assign ram_lane_hi = lane_hi_q;
  assign ram_we      = we_q;

  // ------------------------------
  // Checks
  // ------------------------------
  // Grant only for a held transfer so each one is served once
  a_gnt_while_pending: assert property (
    @(posedge clk) disable iff (!rst_n)
    gnt |-> pending
  );

endmodule

// ==== verilog/lru_arbiter.sv ====
// Least-recently-granted arbiter; grants one requesting master per cycle from an ordered queue
`timescale 1ns/1ps

module lru_arbiter
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [sram_mpa_pkg::NUM_MASTERS-1:0]  req,
  output logic [sram_mpa_pkg::NUM_MASTERS-1:0]  gnt
);

  localparam int N = sram_mpa_pkg::NUM_MASTERS;

  // ------------------------------
  // Queue state
  // ------------------------------
  // One-hot entries, entry zero has the highest priority
  logic [N-1:0] queue [N];
  // Entries at and behind the granted one
  logic [N-1:0] shift_en;
  logic         found;

  // First queue entry with a pending request wins
  always_comb
  begin
    found    = 1'b0;
    gnt      = '0;
    shift_en = '0;
    for (int i = 0; i < N; i++)
    begin
      if (!found && (|(queue[i] & req)))
      begin
        found = 1'b1;
        gnt   = queue[i];
      end
      // Winner and everything behind it move
      if (found)
        shift_en[i] = 1'b1;
    end
  end

  // ------------------------------
  // Queue update
  // ------------------------------
  // Winner goes to the tail, later entries step forward
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < N; i++)
        queue[i] <= N'(1) << i;
    end
    else
    begin
      for (int i = 0; i < N - 1; i++)
      begin
        if (shift_en[i])
          queue[i] <= queue[i+1];
      end
      if (shift_en[N-1])
        queue[N-1] <= gnt;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_gnt_onehot: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(gnt)
  );

  // No grant to an idle master
  a_gnt_has_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gnt & ~req) == '0
  );

endmodule

// ==== verilog/ram_router.sv ====
// SRAM request mux and read return; tracks which master owns the data coming back
`timescale 1ns/1ps

module ram_router
#(
  parameter int ADDR_WIDTH = 12
)
(
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [sram_mpa_pkg::NUM_MASTERS-1:0]  gnt,

  // Processor side, from the AHB front end
  input  logic [ADDR_WIDTH-4:0]                 proc_a,
  input  logic                                  proc_lane_hi,
  input  logic [sram_mpa_pkg::BE_W-1:0]         proc_we,
  input  logic [sram_mpa_pkg::LANE_W-1:0]       proc_wdata,
  output logic [sram_mpa_pkg::LANE_W-1:0]       proc_rdata,

  // DMA0
  input  logic [ADDR_WIDTH-1:0]                 dma0_addr,
  input  logic                                  dma0_trans,
  input  logic                                  dma0_write,
  input  logic [sram_mpa_pkg::BE_W-1:0]         dma0_we,
  input  logic [sram_mpa_pkg::WORD_W-1:0]       dma0_wdata,
  output logic                                  dma0_ready,
  output logic [sram_mpa_pkg::WORD_W-1:0]       dma0_rdata,

  // DMA1
  input  logic [ADDR_WIDTH-1:0]                 dma1_addr,
  input  logic                                  dma1_trans,
  input  logic                                  dma1_write,
  input  logic [sram_mpa_pkg::BE_W-1:0]         dma1_we,
  input  logic [sram_mpa_pkg::WORD_W-1:0]       dma1_wdata,
  output logic                                  dma1_ready,
  output logic [sram_mpa_pkg::WORD_W-1:0]       dma1_rdata,

  // DMA requests, index 0 for DMA0
  output logic [1:0]                            dma_req,

  // SRAM
  output logic                                  ram_cs,
  output logic [ADDR_WIDTH-4:0]                 ram_a,
  output logic [sram_mpa_pkg::BE_W-1:0]         ram_we,
  output logic [sram_mpa_pkg::WORD_W-1:0]       ram_d,
  input  logic [sram_mpa_pkg::WORD_W-1:0]       ram_q
);

  // ------------------------------
  // Local signals
  // ------------------------------
  logic [sram_mpa_pkg::NUM_MASTERS-1:0]  owner;
  logic                                  owner_lane_hi;
  logic [sram_mpa_pkg::BE_W-1:0]         sel_we;
  sram_mpa_pkg::ram_word_u               sel_d;
  sram_mpa_pkg::ram_word_u               merged_d;
  sram_mpa_pkg::ram_word_u               rd_word;

  // ------------------------------
  // Request mux
  // ------------------------------
  // Grant is one-hot, so at most one leg is taken
  always_comb
  begin
    ram_a  = '0;
    sel_we = '0;
    sel_d  = '0;
    if (gnt[sram_mpa_pkg::PROC_ID])
    begin
      ram_a        = proc_a;
      sel_we       = proc_we;
      // Same lane data on both halves so the enables pick one
      sel_d.lane[0] = proc_wdata;
      sel_d.lane[1] = proc_wdata;
    end
    if (gnt[sram_mpa_pkg::DMA0_ID])
    begin
      ram_a  = dma0_addr[ADDR_WIDTH-1:3];
      sel_we = dma0_write ? dma0_we : '0;
      sel_d  = dma0_wdata;
    end
    if (gnt[sram_mpa_pkg::DMA1_ID])
    begin
      ram_a  = dma1_addr[ADDR_WIDTH-1:3];
      sel_we = dma1_write ? dma1_we : '0;
      sel_d  = dma1_wdata;
    end
  end

  // Disabled bytes driven as zero
  always_comb
  begin
    for (int b = 0; b < sram_mpa_pkg::BE_W; b++)
      merged_d.bytes[b] = sel_we[b] ? sel_d.bytes[b] : 8'h00;
  end

  assign ram_cs = |gnt;
  assign ram_we = sel_we;
  assign ram_d  = merged_d;

  // ------------------------------
  // Data owner
  // ------------------------------
  // Owner of the read data arriving next cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      owner <= '0;
    else
      owner <= gnt;
  end

  always_ff @(posedge clk)
  begin
    owner_lane_hi <= proc_lane_hi;
  end

  // Served transfer masked in its ready cycle
  assign dma_req[0] = dma0_trans & ~owner[sram_mpa_pkg::DMA0_ID];
  assign dma_req[1] = dma1_trans & ~owner[sram_mpa_pkg::DMA1_ID];

  // ------------------------------
  // Read return
  // ------------------------------
  assign rd_word    = ram_q;
  assign dma0_rdata = ram_q;
  assign dma1_rdata = ram_q;
  assign dma0_ready = owner[sram_mpa_pkg::DMA0_ID];
  assign dma1_ready = owner[sram_mpa_pkg::DMA1_ID];
  assign proc_rdata = rd_word.lane[owner_lane_hi];

  // No master granted again in the cycle its data returns
  a_no_regrant_in_ready: assert property (
    @(posedge clk) disable iff (!rst_n)
    (gnt & owner) == '0
  );

endmodule

// ==== verilog/sram_mpa.sv ====
// Multi-port SRAM access controller top; one AHB processor port and two DMA ports on one SRAM
`timescale 1ns/1ps

module sram_mpa
#(
  parameter int ADDR_WIDTH = 12
)
(
  input  logic                                clk,
  input  logic                                rst_n,

  // ------------------------------
  // Processor AHB port
  // ------------------------------
  input  logic                                proc_hsel,
  input  logic [ADDR_WIDTH-1:0]               proc_haddr,
  input  logic [1:0]                          proc_htrans,
  input  logic                                proc_hwrite,
  input  logic [1:0]                          proc_hsize,
  input  logic                                proc_hready_in,
  input  logic [sram_mpa_pkg::LANE_W-1:0]     proc_hwdata,
  output logic [sram_mpa_pkg::LANE_W-1:0]     proc_hrdata,
  output logic                                proc_hready,

  // ------------------------------
  // DMA ports
  // ------------------------------
  input  logic [ADDR_WIDTH-1:0]               dma0_addr,
  input  logic                                dma0_trans,
  input  logic                                dma0_write,
  input  logic [sram_mpa_pkg::WORD_W-1:0]     dma0_wdata,
  input  logic [sram_mpa_pkg::BE_W-1:0]       dma0_we,
  output logic [sram_mpa_pkg::WORD_W-1:0]     dma0_rdata,
  output logic                                dma0_ready,

  input  logic [ADDR_WIDTH-1:0]               dma1_addr,
  input  logic                                dma1_trans,
  input  logic                                dma1_write,
  input  logic [sram_mpa_pkg::WORD_W-1:0]     dma1_wdata,
  input  logic [sram_mpa_pkg::BE_W-1:0]       dma1_we,
  output logic [sram_mpa_pkg::WORD_W-1:0]     dma1_rdata,
  output logic                                dma1_ready,

  // ------------------------------
  // External SRAM
  // ------------------------------
  output logic                                ram_cs,
  output logic [ADDR_WIDTH-4:0]               ram_a,
  output logic [sram_mpa_pkg::BE_W-1:0]       ram_we,
  output logic [sram_mpa_pkg::WORD_W-1:0]     ram_d,
  input  logic [sram_mpa_pkg::WORD_W-1:0]     ram_q
);

  // Arbitration vectors, indexed by master ID
  logic [sram_mpa_pkg::NUM_MASTERS-1:0]  req;
  logic [sram_mpa_pkg::NUM_MASTERS-1:0]  gnt;
  logic [1:0]                            dma_req;

  // Processor request after capture
  logic                                  proc_req;
  logic [ADDR_WIDTH-4:0]                 proc_a;
  logic                                  proc_lane_hi;
  logic [sram_mpa_pkg::BE_W-1:0]         proc_we;

  assign req[sram_mpa_pkg::PROC_ID] = proc_req;
  assign req[sram_mpa_pkg::DMA0_ID] = dma_req[0];
  assign req[sram_mpa_pkg::DMA1_ID] = dma_req[1];

  ahb_port #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ahb_port (
    .clk         (clk),
    .rst_n       (rst_n),
    .hsel        (proc_hsel),
    .haddr       (proc_haddr),
    .htrans      (proc_htrans),
    .hwrite      (proc_hwrite),
    .hsize       (proc_hsize),
    .hready_in   (proc_hready_in),
    .hready      (proc_hready),
    .req         (proc_req),
    .gnt         (gnt[sram_mpa_pkg::PROC_ID]),
    .ram_a       (proc_a),
    .ram_lane_hi (proc_lane_hi),
    .ram_we      (proc_we)
  );

  lru_arbiter u_lru_arbiter (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .gnt   (gnt)
  );

  ram_router #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_ram_router (
    .clk          (clk),
    .rst_n        (rst_n),
    .gnt          (gnt),
    .proc_a       (proc_a),
    .proc_lane_hi (proc_lane_hi),
    .proc_we      (proc_we),
    .proc_wdata   (proc_hwdata),
    .proc_rdata   (proc_hrdata),
    .dma0_addr    (dma0_addr),
    .dma0_trans   (dma0_trans),
    .dma0_write   (dma0_write),
    .dma0_we      (dma0_we),
    .dma0_wdata   (dma0_wdata),
    .dma0_ready   (dma0_ready),
    .dma0_rdata   (dma0_rdata),
    .dma1_addr    (dma1_addr),
    .dma1_trans   (dma1_trans),
    .dma1_write   (dma1_write),
    .dma1_we      (dma1_we),
    .dma1_wdata   (dma1_wdata),
    .dma1_ready   (dma1_ready),
    .dma1_rdata   (dma1_rdata),
    .dma_req      (dma_req),
    .ram_cs       (ram_cs),
    .ram_a        (ram_a),
    .ram_we       (ram_we),
    .ram_d        (ram_d),
    .ram_q        (ram_q)
  );

endmodule

// ==== verif/tb_ram_model.sv ====
// Behavioural 64-bit SRAM for the testbench; one-cycle read latency and a log of every selected cycle
`timescale 1ns/1ps

module tb_ram_model
#(
  parameter int AW        = 9,
  parameter int LOG_DEPTH = 1024
)
(
  input  logic                                clk,
  input  logic                                ram_cs,
  input  logic [AW-1:0]                       ram_a,
  input  logic [sram_mpa_pkg::BE_W-1:0]       ram_we,
  input  logic [sram_mpa_pkg::WORD_W-1:0]     ram_d,
  output logic [sram_mpa_pkg::WORD_W-1:0]     ram_q
);

  // Storage, byte view used for enable merging
  sram_mpa_pkg::ram_word_u  mem [2**AW];
  sram_mpa_pkg::ram_word_u  wd;

  // ------------------------------
  // Grant-order log
  // ------------------------------
  // Word address and cycle stamp of each selected cycle
  logic [AW-1:0]  log_a [LOG_DEPTH];
  int             log_t [LOG_DEPTH];
  int             log_n = 0;
  int             cyc = 0;

  assign wd = ram_d;

  // Fill with a pattern built from the whole word address
  initial
  begin
    ram_q = '0;
    for (int i = 0; i < 2**AW; i++)
      mem[i] = {32'(i) * 32'h9e37_79b9, ~32'(i)};
  end

  always @(posedge clk)
  begin
    sram_mpa_pkg::ram_word_u nxt;
    cyc <= cyc + 1;
    if (ram_cs)
    begin
      // Read returns the old word, write merges enabled bytes
      ram_q <= mem[ram_a];
      nxt = mem[ram_a];
      for (int b = 0; b < sram_mpa_pkg::BE_W; b++)
        if (ram_we[b])
          nxt.bytes[b] = wd.bytes[b];
      mem[ram_a] <= nxt;
      if (log_n < LOG_DEPTH)
      begin
        log_a[log_n] <= ram_a;
        log_t[log_n] <= cyc;
      end
      log_n <= log_n + 1;
    end
  end

endmodule

// ==== verif/tb_sram_mpa.sv ====
// Testbench for the SRAM access controller; random AHB and DMA traffic checked against a shadow memory
`timescale 1ns/1ps

module tb_sram_mpa;

  localparam int ADDR_WIDTH = 12;
  localparam int WA_W       = ADDR_WIDTH - 3;
  // Transfer counts per test
  localparam int N_PROC = 16;
  localparam int N_DMA  = 12;
  localparam int N_MIX  = 40;
  localparam int N_COH  = 8;
  localparam int TOTAL  = 3 + 2 * N_PROC + 4 * N_DMA + 3 * N_MIX + 4 * N_COH;
  localparam int LIMIT  = 20 * TOTAL;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    proc_hsel;
  logic [ADDR_WIDTH-1:0]   proc_haddr;
  logic [1:0]              proc_htrans;
  logic                    proc_hwrite;
  logic [1:0]              proc_hsize;
  logic                    proc_hready_in;
  logic [31:0]             proc_hwdata;
  logic [31:0]             proc_hrdata;
  logic                    proc_hready;
  logic [ADDR_WIDTH-1:0]   dma0_addr;
  logic                    dma0_trans;
  logic                    dma0_write;
  logic [63:0]             dma0_wdata;
  logic [7:0]              dma0_we;
  logic [63:0]             dma0_rdata;
  logic                    dma0_ready;
  logic [ADDR_WIDTH-1:0]   dma1_addr;
  logic                    dma1_trans;
  logic                    dma1_write;
  logic [63:0]             dma1_wdata;
  logic [7:0]              dma1_we;
  logic [63:0]             dma1_rdata;
  logic                    dma1_ready;
  logic                    ram_cs;
  logic [WA_W-1:0]         ram_a;
  logic [7:0]              ram_we;
  logic [63:0]             ram_d;
  logic [63:0]             ram_q;

  // Shadow memory and outstanding responses, top bit marks a read
  sram_mpa_pkg::ram_word_u  shadow [2**WA_W];
  logic [32:0]              exp_proc [$];
  logic [64:0]              exp_dma0 [$];
  logic [64:0]              exp_dma1 [$];
  logic [31:0]              lfsr;
  int                       lru [3] = '{0, 1, 2};
  int                       cycle_cnt;
  logic                     hready_d;

  sram_mpa #(.ADDR_WIDTH(ADDR_WIDTH)) dut (.*);
  tb_ram_model #(.AW(WA_W)) u_ram (.*);

  always #4 clk = ~clk;

  // ------------------------------
  // Helpers and reference
  // ------------------------------
  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // New word after a write, only enabled bytes replaced
  function automatic logic [63:0] merge_word(logic [63:0] old, logic [63:0] d, logic [7:0] be);
    logic [63:0] r;
    r = old;
    for (int b = 0; b < 8; b++)
      if (be[b])
        r[8*b +: 8] = d[8*b +: 8];
    return r;
  endfunction

  // AHB size and low address bits to word byte enables
  function automatic logic [7:0] ahb_bytes(logic [2:0] a, logic [1:0] sz);
    if (sz == sram_mpa_pkg::HSIZE_BYTE)
      return 8'h01 << a;
    if (sz == sram_mpa_pkg::HSIZE_HALF)
      return 8'h03 << {a[2:1], 1'b0};
    return 8'h0f << {a[2], 2'b00};
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] align_addr(logic [ADDR_WIDTH-1:0] a, logic [1:0] sz);
    if (sz == sram_mpa_pkg::HSIZE_HALF)
      return {a[ADDR_WIDTH-1:1], 1'b0};
    if (sz == sram_mpa_pkg::HSIZE_WORD)
      return {a[ADDR_WIDTH-1:2], 2'b00};
    return a;
  endfunction

  // Least-recently-granted rule, first queue entry that requests
  function automatic int ref_grant(logic [2:0] rq);
    for (int i = 0; i < 3; i++)
      if (rq[lru[i]])
        return lru[i];
    return -1;
  endfunction

  function automatic void move_to_tail(int m);
    int k;
    k = 0;
    for (int i = 0; i < 3; i++)
    begin
      if (lru[i] != m)
      begin
        lru[k] = lru[i];
        k++;
      end
    end
    lru[2] = m;
  endfunction

  // ------------------------------
  // Bus drivers
  // ------------------------------
  // One AHB transfer; returns data phase length in cycles
  task automatic ahb_xfer(input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [1:0] sz, input logic [31:0] wdata, output int cycles);
    sram_mpa_pkg::ram_word_u w;
    w = shadow[addr[ADDR_WIDTH-1:3]];
    if (wr)
    begin
      shadow[addr[ADDR_WIDTH-1:3]] = merge_word(w, {wdata, wdata}, ahb_bytes(addr[2:0], sz));
      exp_proc.push_back({1'b0, 32'h0});
    end
    else
      exp_proc.push_back({1'b1, w.lane[addr[2]]});
    proc_hsel   <= 1'b1;
    proc_haddr  <= addr;
    proc_htrans <= 2'b10;
    proc_hwrite <= wr;
    proc_hsize  <= sz;
    @(posedge clk);
    // Address phase taken, data phase follows
    proc_hsel   <= 1'b0;
    proc_htrans <= 2'b00;
    proc_hwdata <= wdata;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (!proc_hready);
  endtask

  // One DMA transfer, request held until the ready pulse
  task automatic dma_xfer(input int n, input logic wr, input logic [WA_W-1:0] wa,
                          input logic [63:0] d, input logic [7:0] be);
    logic [2:0] low;
    low = 3'(rand_bits(3));
    if (wr)
      shadow[wa] = merge_word(shadow[wa], d, be);
    if (n == 0)
    begin
      exp_dma0.push_back({!wr, shadow[wa]});
      dma0_trans <= 1'b1;
      dma0_addr  <= {wa, low};
      dma0_write <= wr;
      dma0_wdata <= d;
      dma0_we    <= be;
    end
    else
    begin
      exp_dma1.push_back({!wr, shadow[wa]});
      dma1_trans <= 1'b1;
      dma1_addr  <= {wa, low};
      dma1_write <= wr;
      dma1_wdata <= d;
      dma1_we    <= be;
    end
    do
      @(posedge clk);
    while (!(n == 0 ? dma0_ready : dma1_ready));
  endtask

  // Drop the request on the edge after the ready pulse
  task automatic dma_stop(input int n);
    if (n == 0)
      dma0_trans <= 1'b0;
    else
      dma1_trans <= 1'b0;
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  // Upper two word address bits name the master that owns a region
  task automatic startup_test();
    int cyc;
    fork
      ahb_xfer(1'b1, 12'h010, sram_mpa_pkg::HSIZE_WORD, rand_bits(32), cyc);
      begin
        @(posedge clk);
        dma_xfer(0, 1'b1, 9'h080, {rand_bits(32), rand_bits(32)}, 8'hff);
        dma_stop(0);
      end
      begin
        @(posedge clk);
        dma_xfer(1, 1'b1, 9'h100, {rand_bits(32), rand_bits(32)}, 8'hff);
        dma_stop(1);
      end
    join
    for (int k = 0; k < 3; k++)
      assert (u_ram.log_a[k][WA_W-1 -: 2] == 2'(k))
      else fail_stop($sformatf("CHECK FAILED ram_a grant %0d master got %h exp %h",
                               k, u_ram.log_a[k][WA_W-1 -: 2], k));
    assert (u_ram.log_t[1] == u_ram.log_t[0] + 1 && u_ram.log_t[2] == u_ram.log_t[1] + 1)
    else fail_stop("grants after reset did not come in consecutive cycles");
  endtask

  // Sized writes then word reads, no contention
  task automatic proc_test();
    logic [ADDR_WIDTH-1:0] a [N_PROC];
    logic [31:0]           r;
    logic [1:0]            sz;
    int                    cyc;
    for (int i = 0; i < N_PROC; i++)
    begin
      r = rand_bits(12);
      sz = (r[11:10] == 2'b11) ? sram_mpa_pkg::HSIZE_WORD : r[11:10];
      a[i] = align_addr({2'b00, r[9:0]}, sz);
      ahb_xfer(1'b1, a[i], sz, rand_bits(32), cyc);
      assert (cyc == 2)
      else fail_stop($sformatf("CHECK FAILED proc_hready wait cycles got %h exp %h", cyc, 2));
    end
    for (int i = 0; i < N_PROC; i++)
    begin
      ahb_xfer(1'b0, {a[i][ADDR_WIDTH-1:2], 2'b00}, sram_mpa_pkg::HSIZE_WORD, '0, cyc);
      assert (cyc == 2)
      else fail_stop($sformatf("CHECK FAILED proc_hready wait cycles got %h exp %h", cyc, 2));
    end
  endtask

  // Masked writes then reads of the same words
  task automatic dma_test(input int n);
    logic [WA_W-1:0] wa [N_DMA];
    logic [31:0]     r;
    for (int i = 0; i < N_DMA; i++)
    begin
      r = rand_bits(7);
      wa[i] = {2'(n + 1), r[6:0]};
      dma_xfer(n, 1'b1, wa[i], {rand_bits(32), rand_bits(32)}, 8'(rand_bits(8)));
    end
    for (int i = 0; i < N_DMA; i++)
      dma_xfer(n, 1'b0, wa[i], '0, '0);
    dma_stop(n);
  endtask

  task automatic proc_mix();
    logic [31:0] r;
    logic [1:0]  sz;
    int          cyc;
    for (int i = 0; i < N_MIX; i++)
    begin
      r = rand_bits(13);
      sz = (r[12:11] == 2'b11) ? sram_mpa_pkg::HSIZE_WORD : r[12:11];
      ahb_xfer(r[10], align_addr({2'b00, r[9:0]}, sz), sz, rand_bits(32), cyc);
    end
  endtask

  task automatic dma_mix(input int n);
    logic [31:0] r;
    for (int i = 0; i < N_MIX; i++)
    begin
      r = rand_bits(8);
      dma_xfer(n, r[7], {2'(n + 1), r[6:0]}, {rand_bits(32), rand_bits(32)}, 8'(rand_bits(8)));
    end
    dma_stop(n);
  endtask

  // Shared region 3, each port reads what another wrote
  task automatic coherence_test();
    logic [31:0]     r;
    logic [WA_W-1:0] wa;
    int              cyc;
    for (int i = 0; i < N_COH; i++)
    begin
      r = rand_bits(8);
      wa = {2'b11, r[6:0]};
      ahb_xfer(1'b1, {wa, r[7], 2'b00}, sram_mpa_pkg::HSIZE_WORD, rand_bits(32), cyc);
      dma_xfer(i % 2, 1'b0, wa, '0, '0);
      dma_stop(i % 2);
      dma_xfer(1 - i % 2, 1'b1, wa, {rand_bits(32), rand_bits(32)}, 8'(rand_bits(8)));
      dma_stop(1 - i % 2);
      ahb_xfer(1'b0, {wa, ~r[7], 2'b00}, sram_mpa_pkg::HSIZE_WORD, '0, cyc);
    end
  endtask

  // ------------------------------
  // Response and grant checker
  // ------------------------------
  always @(posedge clk)
  begin
    logic [2:0]  rq;
    logic [32:0] pe;
    logic [64:0] de;
    int          exp_m;
    int          obs_m;
    if (!rst_n)
    begin
      lru = '{0, 1, 2};
      hready_d = 1'b1;
      cycle_cnt = 0;
    end
    else
    begin
      cycle_cnt++;
      if (cycle_cnt > LIMIT)
        fail_stop("timeout, the transfers did not finish within the cycle limit");
      // Requests of the cycle just ended, as seen on the ports
      rq[sram_mpa_pkg::PROC_ID] = !proc_hready;
      rq[sram_mpa_pkg::DMA0_ID] = dma0_trans && !dma0_ready;
      rq[sram_mpa_pkg::DMA1_ID] = dma1_trans && !dma1_ready;
      exp_m = ref_grant(rq);
      assert (ram_cs == (exp_m >= 0))
      else fail_stop($sformatf("CHECK FAILED ram_cs got %h exp %h", ram_cs, exp_m >= 0));
      obs_m = ram_a[WA_W-1 -: 2];
      // Shared region hides the master
      if (ram_cs && obs_m != 3)
        assert (obs_m == exp_m)
        else fail_stop($sformatf("CHECK FAILED ram_a master got %h exp %h", obs_m, exp_m));
      if (exp_m >= 0)
        move_to_tail(exp_m);
      // Processor transfer ends when hready comes back
      if (proc_hready && !hready_d)
      begin
        assert (exp_proc.size() > 0)
        else fail_stop("processor transfer ended with none outstanding");
        pe = exp_proc.pop_front();
        if (pe[32])
          assert (proc_hrdata == pe[31:0])
          else fail_stop($sformatf("CHECK FAILED proc_hrdata got %h exp %h",
                                   proc_hrdata, pe[31:0]));
      end
      hready_d = proc_hready;
      if (dma0_ready)
      begin
        assert (exp_dma0.size() > 0)
        else fail_stop("DMA0 ready pulse with no transfer outstanding");
        de = exp_dma0.pop_front();
        if (de[64])
          assert (dma0_rdata == de[63:0])
          else fail_stop($sformatf("CHECK FAILED dma0_rdata got %h exp %h", dma0_rdata, de[63:0]));
      end
      if (dma1_ready)
      begin
        assert (exp_dma1.size() > 0)
        else fail_stop("DMA1 ready pulse with no transfer outstanding");
        de = exp_dma1.pop_front();
        if (de[64])
          assert (dma1_rdata == de[63:0])
          else fail_stop($sformatf("CHECK FAILED dma1_rdata got %h exp %h", dma1_rdata, de[63:0]));
      end
    end
  end

  // ------------------------------
  // Sequence
  // ------------------------------
  initial
  begin
    lfsr = 32'hd667;
    rst_n = 1'b0;
    proc_hsel = 1'b0;
    proc_haddr = '0;
    proc_htrans = 2'b00;
    proc_hwrite = 1'b0;
    proc_hsize = sram_mpa_pkg::HSIZE_WORD;
    proc_hready_in = 1'b1;
    proc_hwdata = '0;
    dma0_addr = '0;
    dma0_trans = 1'b0;
    dma0_write = 1'b0;
    dma0_wdata = '0;
    dma0_we = '0;
    dma1_addr = '0;
    dma1_trans = 1'b0;
    dma1_write = 1'b0;
    dma1_wdata = '0;
    dma1_we = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < 2**WA_W; i++)
      shadow[i] = u_ram.mem[i];
    // Arbitration order must be checked straight out of reset
    startup_test();
    proc_test();
    fork
      dma_test(0);
      dma_test(1);
    join
    fork
      proc_mix();
      dma_mix(0);
      dma_mix(1);
    join
    coherence_test();
    @(posedge clk);
    if (exp_proc.size() == 0 && exp_dma0.size() == 0 && exp_dma1.size() == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
      fail_stop("responses still outstanding at the end of the run");
  end

endmodule

// ==== src.f ====
verilog/sram_mpa_pkg.sv
verilog/ahb_port.sv
verilog/lru_arbiter.sv
verilog/ram_router.sv
verilog/sram_mpa.sv
verif/tb_ram_model.sv
verif/tb_sram_mpa.sv
